/* Bender.yml */
package:
  name: issue_queue

sources:
  - common/iq_pkg.sv
  - rtl/op_decode.sv
  - rtl/iq_ctrl.sv
  - rtl/iq_entries.sv
  - rtl/issue_select.sv
  - rtl/issue_queue.sv

  - target: test
    files:
      - verif/tb_issue_queue.sv

/* all.f */
common/iq_pkg.sv
rtl/op_decode.sv
rtl/iq_ctrl.sv
rtl/iq_entries.sv
rtl/issue_select.sv
rtl/issue_queue.sv
verif/tb_issue_queue.sv

/* common/iq_pkg.sv */
package iq_pkg;

    ////////////////////////////////////////
    // widths
    ////////////////////////////////////////

    localparam int XLEN      = 32;
    localparam int TAG_W     = 6;
    localparam int NUM_PREGS = 64;
    // sized for the largest unit count, 4
    localparam int FU_IDX_W  = 2;

    typedef logic [XLEN-1:0]     data_t;
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [FU_IDX_W-1:0] fu_idx_t;

    ////////////////////////////////////////
    // alu operations
    ////////////////////////////////////////

    typedef enum logic [3:0] {
        OP_NONE = 4'd0,
        OP_ADD  = 4'd1,
        OP_ADDI = 4'd2,
        OP_LUI  = 4'd3,
        OP_ORI  = 4'd4,
        OP_XOR  = 4'd5,
        OP_SRAI = 4'd6
    } op_e;

    ////////////////////////////////////////
    // payloads
    ////////////////////////////////////////

    // from rename, values already read from the register file
    typedef struct packed {
        data_t      pc;
        logic [6:0] opcode;
        logic [2:0] funct3;
        tag_t       rs1_tag;
        data_t      rs1_val;
        tag_t       rs2_tag;
        data_t      rs2_val;
        data_t      imm;
        tag_t       rd_tag;
    } dispatch_t;

    // one result bus per functional unit
    typedef struct packed {
        logic  valid;
        tag_t  tag;
        data_t value;
    } wakeup_t;

    typedef struct packed {
        logic    valid;
        op_e     op;
        data_t   pc;
        tag_t    rd;
        tag_t    src1_tag;
        logic    src1_ready;
        data_t   src1_val;
        tag_t    src2_tag;
        logic    src2_ready;
        data_t   src2_val;
        data_t   imm;
        fu_idx_t fu;
    } iq_entry_t;

    typedef struct packed {
        logic  valid;
        op_e   op;
        data_t pc;
        tag_t  rd;
        data_t src1_val;
        data_t src2_val;
        data_t imm;
    } issue_t;

endpackage

/* rtl/iq_ctrl.sv */
module iq_ctrl #(
    parameter int NUM_ENTRIES = 16,
    parameter int NUM_FU      = 3
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   dispatch_valid,
    input  iq_pkg::op_e            op,
    input  logic [NUM_ENTRIES-1:0] entry_valid,
    output logic [NUM_ENTRIES-1:0] alloc,
    output iq_pkg::fu_idx_t        alloc_fu,
    output logic                   stall
);

    localparam iq_pkg::fu_idx_t LAST_FU = iq_pkg::fu_idx_t'(NUM_FU - 1);

    logic [NUM_ENTRIES-1:0] free_first;
    logic                   do_alloc;
    iq_pkg::fu_idx_t        rr_q;

    ////////////////////////////////////////
    // allocation
    ////////////////////////////////////////

    // lowest clear bit of the valid vector, one-hot
    assign free_first = ~entry_valid & (entry_valid + 1'b1);

    // queue full
    assign stall = &entry_valid;

    // illegal ops never take a slot
    assign do_alloc = dispatch_valid && (op != iq_pkg::OP_NONE) && !stall;

    assign alloc    = do_alloc ? free_first : '0;
    assign alloc_fu = rr_q;

    ////////////////////////////////////////
    // round-robin fu binding
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rr_q <= '0;
        end else if (do_alloc) begin
            if (rr_q == LAST_FU) begin
                rr_q <= '0;
            end else begin
                rr_q <= rr_q + 1'b1;
            end
        end
    end

endmodule

/* rtl/iq_entries.sv */
module iq_entries #(
    parameter int NUM_ENTRIES = 16,
    parameter int NUM_FU      = 3
) (
    input  logic                                clk,
    input  logic                                rstn,
    input  iq_pkg::dispatch_t                   dispatch,
    input  iq_pkg::op_e                         op,
    input  logic [NUM_ENTRIES-1:0]              alloc,
    input  iq_pkg::fu_idx_t                     alloc_fu,
    input  logic [iq_pkg::NUM_PREGS-1:0]        reg_ready,
    input  iq_pkg::wakeup_t [NUM_FU-1:0]        wakeup,
    input  logic [NUM_ENTRIES-1:0]              clear,
    output iq_pkg::iq_entry_t [NUM_ENTRIES-1:0] entries,
    output logic [NUM_ENTRIES-1:0]              entry_valid
);

    logic [NUM_ENTRIES-1:0] valid_q;
    iq_pkg::iq_entry_t      slot_q [NUM_ENTRIES];
    iq_pkg::iq_entry_t      new_entry;
    logic                   new1_hit;
    logic                   new2_hit;
    iq_pkg::data_t          new1_val;
    iq_pkg::data_t          new2_val;
    logic [NUM_ENTRIES-1:0] s1_hit;
    logic [NUM_ENTRIES-1:0] s2_hit;
    iq_pkg::data_t          s1_val [NUM_ENTRIES];
    iq_pkg::data_t          s2_val [NUM_ENTRIES];

    // tag compare against all result buses, lowest fu wins
    function automatic void bcast_match(
        input  iq_pkg::tag_t                 tag,
        input  iq_pkg::wakeup_t [NUM_FU-1:0] bus,
        output logic                         hit,
        output iq_pkg::data_t                value
    );
        hit   = 1'b0;
        value = '0;
        for (int f = NUM_FU - 1; f >= 0; f--) begin
            if (bus[f].valid && (bus[f].tag == tag)) begin
                hit   = 1'b1;
                value = bus[f].value;
            end
        end
    endfunction

    ////////////////////////////////////////
    // incoming entry
    ////////////////////////////////////////

    always_comb begin
        bcast_match(dispatch.rs1_tag, wakeup, new1_hit, new1_val);
        bcast_match(dispatch.rs2_tag, wakeup, new2_hit, new2_val);
        new_entry.valid      = 1'b1;
        new_entry.op         = op;
        new_entry.pc         = dispatch.pc;
        new_entry.rd         = dispatch.rd_tag;
        new_entry.src1_tag   = dispatch.rs1_tag;
        new_entry.src1_ready = new1_hit || reg_ready[dispatch.rs1_tag];
        // same-cycle broadcast is newer than the register file
        new_entry.src1_val   = new1_hit ? new1_val : dispatch.rs1_val;
        new_entry.src2_tag   = dispatch.rs2_tag;
        new_entry.src2_ready = new2_hit || reg_ready[dispatch.rs2_tag];
        new_entry.src2_val   = new2_hit ? new2_val : dispatch.rs2_val;
        new_entry.imm        = dispatch.imm;
        new_entry.fu         = alloc_fu;
    end

    ////////////////////////////////////////
    // stored entries
    ////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            bcast_match(slot_q[i].src1_tag, wakeup, s1_hit[i], s1_val[i]);
            bcast_match(slot_q[i].src2_tag, wakeup, s2_hit[i], s2_val[i]);
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_q <= '0;
        end else begin
            valid_q <= (valid_q & ~clear) | alloc;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (alloc[i]) begin
                slot_q[i] <= new_entry;
            end else if (valid_q[i]) begin
                // wakeup of waiting sources
                if (!slot_q[i].src1_ready && s1_hit[i]) begin
                    slot_q[i].src1_ready <= 1'b1;
                    slot_q[i].src1_val   <= s1_val[i];
                end
                if (!slot_q[i].src2_ready && s2_hit[i]) begin
                    slot_q[i].src2_ready <= 1'b1;
                    slot_q[i].src2_val   <= s2_val[i];
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            entries[i]       = slot_q[i];
            entries[i].valid = valid_q[i];
        end
    end

    assign entry_valid = valid_q;

endmodule

/* rtl/issue_queue.sv */
module issue_queue #(
    parameter int NUM_ENTRIES = 16,
    parameter int NUM_FU      = 3
) (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         dispatch_valid,
    input  iq_pkg::dispatch_t            dispatch,
    input  logic [iq_pkg::NUM_PREGS-1:0] reg_ready,
    input  iq_pkg::wakeup_t [NUM_FU-1:0] wakeup,
    input  logic [NUM_FU-1:0]            fu_ready,
    output iq_pkg::issue_t [NUM_FU-1:0]  issue,
    output logic                         stall
);

    iq_pkg::op_e                         op;
    logic [NUM_ENTRIES-1:0]              alloc;
    iq_pkg::fu_idx_t                     alloc_fu;
    logic [NUM_ENTRIES-1:0]              entry_valid;
    logic [NUM_ENTRIES-1:0]              clear;
    iq_pkg::iq_entry_t [NUM_ENTRIES-1:0] entries;

    op_decode u_op_decode (
        .opcode (dispatch.opcode),
        .funct3 (dispatch.funct3),
        .op     (op)
    );

    // allocation and fu binding
    iq_ctrl #(
        .NUM_ENTRIES (NUM_ENTRIES),
        .NUM_FU      (NUM_FU)
    ) u_iq_ctrl (
        .clk            (clk),
        .rstn           (rstn),
        .dispatch_valid (dispatch_valid),
        .op             (op),
        .entry_valid    (entry_valid),
        .alloc          (alloc),
        .alloc_fu       (alloc_fu),
        .stall          (stall)
    );

    iq_entries #(
        .NUM_ENTRIES (NUM_ENTRIES),
        .NUM_FU      (NUM_FU)
    ) u_iq_entries (
        .clk         (clk),
        .rstn        (rstn),
        .dispatch    (dispatch),
        .op          (op),
        .alloc       (alloc),
        .alloc_fu    (alloc_fu),
        .reg_ready   (reg_ready),
        .wakeup      (wakeup),
        .clear       (clear),
        .entries     (entries),
        .entry_valid (entry_valid)
    );

    // select frees the issued entry at the issue edge
    issue_select #(
        .NUM_ENTRIES (NUM_ENTRIES),
        .NUM_FU      (NUM_FU)
    ) u_issue_select (
        .clk      (clk),
        .rstn     (rstn),
        .entries  (entries),
        .fu_ready (fu_ready),
        .clear    (clear),
        .issue    (issue)
    );

endmodule

/* rtl/issue_select.sv */
module issue_select #(
    parameter int NUM_ENTRIES = 16,
    parameter int NUM_FU      = 3
) (
    input  logic                                clk,
    input  logic                                rstn,
    input  iq_pkg::iq_entry_t [NUM_ENTRIES-1:0] entries,
    input  logic [NUM_FU-1:0]                   fu_ready,
    output logic [NUM_ENTRIES-1:0]              clear,
    output iq_pkg::issue_t [NUM_FU-1:0]         issue
);

    localparam int IDX_W = (NUM_ENTRIES > 1) ? $clog2(NUM_ENTRIES) : 1;

    logic [NUM_ENTRIES-1:0] eligible;
    logic [NUM_FU-1:0]      pick_vld;
    logic [IDX_W-1:0]       pick_idx [NUM_FU];
    iq_pkg::issue_t         pick_data [NUM_FU];
    logic [NUM_FU-1:0]      issue_vld_q;
    iq_pkg::issue_t         issue_q [NUM_FU];

    always_comb begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            eligible[i] = entries[i].valid && entries[i].src1_ready && entries[i].src2_ready;
        end
    end

    ////////////////////////////////////////
    // per-fu pick
    ////////////////////////////////////////

    // entries are bound to one fu, so two picks never collide
    always_comb begin
        clear = '0;
        for (int f = 0; f < NUM_FU; f++) begin
            pick_vld[f] = 1'b0;
            pick_idx[f] = '0;
            // scan downwards, lowest index ends up winning
            for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
                if (fu_ready[f] && eligible[i] && (entries[i].fu == iq_pkg::fu_idx_t'(f))) begin
                    pick_vld[f] = 1'b1;
                    pick_idx[f] = IDX_W'(i);
                end
            end
            if (pick_vld[f]) begin
                clear[pick_idx[f]] = 1'b1;
            end
            pick_data[f].valid    = 1'b1;
            pick_data[f].op       = entries[pick_idx[f]].op;
            pick_data[f].pc       = entries[pick_idx[f]].pc;
            pick_data[f].rd       = entries[pick_idx[f]].rd;
            pick_data[f].src1_val = entries[pick_idx[f]].src1_val;
            pick_data[f].src2_val = entries[pick_idx[f]].src2_val;
            pick_data[f].imm      = entries[pick_idx[f]].imm;
        end
    end

    ////////////////////////////////////////
    // issue registers
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            issue_vld_q <= '0;
        end else begin
            issue_vld_q <= pick_vld;
        end
    end

    always_ff @(posedge clk) begin
        for (int f = 0; f < NUM_FU; f++) begin
            if (pick_vld[f]) begin
                issue_q[f] <= pick_data[f];
            end
        end
    end

    always_comb begin
        for (int f = 0; f < NUM_FU; f++) begin
            issue[f]       = issue_q[f];
            issue[f].valid = issue_vld_q[f];
        end
    end

endmodule

/* rtl/op_decode.sv */
module op_decode (
    input  logic [6:0]  opcode,
    input  logic [2:0]  funct3,
    output iq_pkg::op_e op
);

    // major opcodes the alu pipes accept
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    always_comb begin
        op = iq_pkg::OP_NONE;
        case (opcode)
            OPC_OP: begin
                // only add of the r-type group
                if (funct3 == 3'b000) begin
                    op = iq_pkg::OP_ADD;
                end
            end
            OPC_OP_IMM: begin
                case (funct3)
                    3'b000:  op = iq_pkg::OP_ADDI;
                    3'b100:  op = iq_pkg::OP_XOR;
                    3'b101:  op = iq_pkg::OP_SRAI;
                    3'b110:  op = iq_pkg::OP_ORI;
                    default: op = iq_pkg::OP_NONE;
                endcase
            end
            OPC_LUI: begin
                op = iq_pkg::OP_LUI;
            end
            // loads, stores and anything else are not queued
            default: begin
                op = iq_pkg::OP_NONE;
            end
        endcase
    end

endmodule

/* verif/tb_issue_queue.sv */
module tb_issue_queue;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_ENTRIES = 16;
    localparam int NUM_FU      = 3;
    localparam int TIMEOUT     = 100;

    localparam logic [6:0] OPC_OP   = 7'b0110011;
    localparam logic [6:0] OPC_IMM  = 7'b0010011;
    localparam logic [6:0] OPC_LUI  = 7'b0110111;
    localparam logic [6:0] OPC_LOAD = 7'b0000011;

    logic                         clk = 1'b0;
    logic                         rstn;
    logic                         dispatch_valid;
    iq_pkg::dispatch_t            dispatch;
    logic [iq_pkg::NUM_PREGS-1:0] reg_ready;
    iq_pkg::wakeup_t [NUM_FU-1:0] wakeup;
    logic [NUM_FU-1:0]            fu_ready;
    iq_pkg::issue_t [NUM_FU-1:0]  issue;
    logic                         stall;

    logic [31:0]    lcg_state = 32'hcf39;
    int             ncyc = 0;
    int             last_sent;
    int             rr_model = 0;
    iq_pkg::issue_t got_q [$];
    int             got_fu [$];
    int             got_cyc [$];
    iq_pkg::issue_t exp_q [$];
    int             exp_fu [$];

    always #50 clk = ~clk;

    issue_queue UUT (
        .clk            (clk),
        .rstn           (rstn),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .reg_ready      (reg_ready),
        .wakeup         (wakeup),
        .fu_ready       (fu_ready),
        .issue          (issue),
        .stall          (stall)
    );

    // issue strobes logged at the falling edge
    always @(negedge clk) begin
        ncyc = ncyc + 1;
        for (int f = 0; f < NUM_FU; f++) begin
            if (issue[f].valid) begin
                got_q.push_back(issue[f]);
                got_fu.push_back(f);
                got_cyc.push_back(ncyc);
            end
        end
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    task automatic stop_run(input string what);
        $display("%s", what);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // tag from the upper bits of the lcg state
    function automatic iq_pkg::tag_t rnd_tag();
        return iq_pkg::tag_t'(lcg_next() >> 26);
    endfunction

    function automatic iq_pkg::dispatch_t make_op(input logic [6:0] opcode,
                                                  input logic [2:0] funct3,
                                                  input iq_pkg::tag_t rs1,
                                                  input iq_pkg::tag_t rs2);
        iq_pkg::dispatch_t d;
        d.pc      = lcg_next() & ~32'h3;
        d.opcode  = opcode;
        d.funct3  = funct3;
        d.rs1_tag = rs1;
        d.rs1_val = lcg_next();
        d.rs2_tag = rs2;
        d.rs2_val = lcg_next();
        d.imm     = lcg_next();
        d.rd_tag  = rnd_tag();
        return d;
    endfunction

    task automatic check_op(input string name, input iq_pkg::op_e got, input iq_pkg::op_e exp);
        if (got !== exp) begin
            stop_run($sformatf("** Error at %0t: %s got %0d, expected %0d",
                               $time, name, got, exp));
        end
    endtask

    task automatic check_issue(input string name, input iq_pkg::issue_t got,
                               input iq_pkg::issue_t exp);
        check_op({name, ".op"}, got.op, exp.op);
        if (got !== exp) begin
            stop_run($sformatf("** Error at %0t: %s got %h, expected %h",
                               $time, name, got, exp));
        end
    endtask

    task automatic check_stall(input logic exp);
        @(negedge clk);
        if (stall !== exp) begin
            stop_run($sformatf("** Error at %0t: stall got %b, expected %b", $time, stall, exp));
        end
    endtask

    // queued_as of OP_NONE marks a dispatch that must not queue
    task automatic send(input iq_pkg::dispatch_t d, input iq_pkg::op_e queued_as);
        iq_pkg::issue_t e;
        @(posedge clk);
        dispatch_valid <= 1'b1;
        dispatch       <= d;
        last_sent = ncyc;
        if (queued_as != iq_pkg::OP_NONE) begin
            e.valid    = 1'b1;
            e.op       = queued_as;
            e.pc       = d.pc;
            e.rd       = d.rd_tag;
            e.src1_val = d.rs1_val;
            e.src2_val = d.rs2_val;
            e.imm      = d.imm;
            exp_q.push_back(e);
            exp_fu.push_back(rr_model);
            rr_model = (rr_model + 1) % NUM_FU;
        end
    endtask

    task automatic idle();
        @(posedge clk);
        dispatch_valid <= 1'b0;
    endtask

    task automatic quiet(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic wait_issues(input int n);
        int t;
        t = 0;
        while (got_q.size() < n) begin
            if (t == TIMEOUT) begin
                stop_run($sformatf("timed out waiting for %0d issues, saw %0d", n, got_q.size()));
            end
            @(posedge clk);
            t++;
        end
    endtask

    // pair every logged issue with the oldest expected entry on the same fu
    task automatic match_issues();
        int k;
        while (got_q.size() > 0) begin
            k = 0;
            while (k < exp_q.size() && exp_fu[k] != got_fu[0]) begin
                k++;
            end
            if (k == exp_q.size()) begin
                stop_run($sformatf("unexpected issue on FU %0d", got_fu[0]));
            end else begin
                check_issue($sformatf("issue[%0d]", got_fu[0]), got_q[0], exp_q[k]);
                got_q.delete(0);
                got_fu.delete(0);
                got_cyc.delete(0);
                exp_q.delete(k);
                exp_fu.delete(k);
            end
        end
        if (exp_q.size() != 0) begin
            stop_run($sformatf("%0d expected issues never appeared", exp_q.size()));
        end
    endtask

    ////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////

    task automatic test_reset();
        @(negedge clk);
        for (int f = 0; f < NUM_FU; f++) begin
            if (issue[f].valid !== 1'b0) begin
                stop_run($sformatf("** Error at %0t: issue[%0d].valid got %b, expected 0",
                                   $time, f, issue[f].valid));
            end
        end
        check_stall(1'b0);
    endtask

    task automatic test_round_robin();
        int k0;
        send(make_op(OPC_OP, 3'b000, rnd_tag(), rnd_tag()), iq_pkg::OP_ADD);
        k0 = last_sent;
        send(make_op(OPC_IMM, 3'b000, rnd_tag(), rnd_tag()), iq_pkg::OP_ADDI);
        send(make_op(OPC_LUI, 3'b000, rnd_tag(), rnd_tag()), iq_pkg::OP_LUI);
        idle();
        wait_issues(3);
        for (int i = 0; i < 3; i++) begin
            if (got_fu[i] != i || got_cyc[i] != k0 + 3 + i) begin
                stop_run($sformatf("op %0d issued on FU %0d in cycle %0d, expected FU %0d in %0d",
                                   i, got_fu[i], got_cyc[i], i, k0 + 3 + i));
            end
        end
        match_issues();
    endtask

    task automatic test_wakeup();
        iq_pkg::tag_t   t;
        iq_pkg::data_t  v;
        iq_pkg::issue_t e;
        int             f;
        int             k;
        t = rnd_tag();
        v = lcg_next();
        f = lcg_next() % NUM_FU;
        @(posedge clk);
        reg_ready[t] <= 1'b0;
        send(make_op(OPC_IMM, 3'b110, t, iq_pkg::tag_t'(t + 1)), iq_pkg::OP_ORI);
        idle();
        quiet(5);
        if (got_q.size() != 0) begin
            stop_run("ORI issued before its source was woken up");
        end
        @(posedge clk);
        wakeup[f] <= {1'b1, t, v};
        k = ncyc;
        @(posedge clk);
        wakeup[f] <= '0;
        wait_issues(1);
        if (got_cyc[0] != k + 3) begin
            stop_run($sformatf("ORI issued in cycle %0d, expected %0d", got_cyc[0], k + 3));
        end
        // broadcast value replaces the register-file value
        e = exp_q[0];
        e.src1_val = v;
        exp_q[0] = e;
        match_issues();
        reg_ready[t] <= 1'b1;
    endtask

    task automatic test_backpressure();
        int b;
        b = rr_model;
        @(posedge clk);
        fu_ready[b] <= 1'b0;
        send(make_op(OPC_IMM, 3'b100, rnd_tag(), rnd_tag()), iq_pkg::OP_XOR);
        idle();
        quiet(5);
        if (got_q.size() != 0) begin
            stop_run("XOR issued while its FU was not ready");
        end
        @(posedge clk);
        fu_ready[b] <= 1'b1;
        wait_issues(1);
        quiet(5);
        if (got_q.size() != 1) begin
            stop_run($sformatf("XOR issued %0d times instead of once", got_q.size()));
        end
        match_issues();
    endtask

    task automatic test_full();
        @(posedge clk);
        fu_ready <= '0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            send(make_op(OPC_IMM, 3'b000, rnd_tag(), rnd_tag()), iq_pkg::OP_ADDI);
        end
        // dropped because the queue is full when it is sampled
        send(make_op(OPC_IMM, 3'b000, rnd_tag(), rnd_tag()), iq_pkg::OP_NONE);
        check_stall(1'b1);
        idle();
        quiet(3);
        if (got_q.size() != 0) begin
            stop_run("issue seen while no FU was ready");
        end
        @(posedge clk);
        fu_ready <= '1;
        wait_issues(NUM_ENTRIES);
        quiet(5);
        if (got_q.size() != NUM_ENTRIES) begin
            stop_run($sformatf("full queue drained with %0d issues", got_q.size()));
        end
        check_stall(1'b0);
        match_issues();
    endtask

    task automatic test_illegal();
        send(make_op(OPC_LOAD, 3'b010, rnd_tag(), rnd_tag()), iq_pkg::OP_NONE);
        idle();
        quiet(5);
        if (got_q.size() != 0) begin
            stop_run("load opcode was issued");
        end
        // bound to the fu the pointer held before the load
        send(make_op(OPC_IMM, 3'b101, rnd_tag(), rnd_tag()), iq_pkg::OP_SRAI);
        idle();
        wait_issues(1);
        quiet(3);
        match_issues();
    endtask

    initial begin
        rstn           = 1'b0;
        dispatch_valid = 1'b0;
        dispatch       = '0;
        reg_ready      = '1;
        wakeup         = '0;
        fu_ready       = '1;
        repeat (4) @(posedge clk);
        rstn <= 1'b1;
        test_reset();
        test_round_robin();
        test_wakeup();
        test_backpressure();
        test_full();
        test_illegal();
        $display(">>> PASS");
        $finish;
    end

endmodule
